/* Bender.yml */
package:
  name: usb_transaction

sources:
  - include_dirs:
      - design
    files:
      - design/usb_pkg.sv
      - design/xfer_pkg.sv
      - design/usb_token_decoder.sv
      - design/usb_transaction_seq.sv
      - design/usb_handshake_tx.sv
      - design/usb_transaction.sv

  - target: test
    include_dirs:
      - design
      - tb
    files:
      - tb/tb_usb_transaction.sv

/* design/usb_defines.svh */
`ifndef USB_DEFINES_SVH
`define USB_DEFINES_SVH

// Bulk endpoint numbers, as carried in the 4-bit ENDP token field
`define USB_ENDPOINT1 4'd1
`define USB_ENDPOINT2 4'd2

// Endpoints that may also accept SETUP tokens
// EP0 always does, so it has no flag
`define USB_EP1_CONTROL 1'b0
`define USB_EP2_CONTROL 1'b1

// Setup stage DATA0 payload, in bytes
`define USB_SETUP_BYTES 8

`endif

/* design/usb_handshake_tx.sv */
`timescale 1ns/1ps

module usb_handshake_tx (
  input  logic               clock_i,
  input  logic               reset_i,
  input  logic               hsk_req_i,
  input  usb_pkg::hsk_type_t hsk_req_type_i,
  input  logic               hsk_sent_i,
  output logic               hsk_send_o,
  output usb_pkg::hsk_type_t hsk_type_o,
  output logic               hsk_busy_o
);

  import usb_pkg::*;

  logic      send_q;
  hsk_type_t type_q;

  // Send line held until the encoder reports completion
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      send_q <= 1'b0;
    end else if (hsk_req_i) begin
      send_q <= 1'b1;
    end else if (send_q && hsk_sent_i) begin
      send_q <= 1'b0;
    end
  end

  // Handshake code, captured with the request
  always_ff @(posedge clock_i) begin
    if (hsk_req_i) begin
      type_q <= hsk_req_type_i;
    end
  end

  assign hsk_send_o = send_q;
  assign hsk_type_o = type_q;
  // Busy spans the whole send, ends the cycle after hsk_sent
  assign hsk_busy_o = send_q;

  // Type and send line hold until the encoder takes them
  assert property (@(posedge clock_i) disable iff (reset_i)
    hsk_send_o && !hsk_sent_i |=> hsk_send_o && $stable(hsk_type_o))
    else $error("handshake dropped or changed before hsk_sent");

endmodule

/* design/usb_pkg.sv */
`include "usb_defines.svh"

package usb_pkg;

  // Token PID bits [3:2], as delivered by the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake PID bits [3:2], both directions
  typedef enum logic [1:0] {
    HSK_ACK   = 2'b00,
    HSK_NAK   = 2'b10,
    HSK_STALL = 2'b11
  } hsk_type_t;

  // Decoded token packet
  typedef struct packed {
    tok_type_t  tok_type;
    logic [6:0] addr;
    logic [3:0] endp;
  } usb_token_t;

  // Standard device request layout
  // Byte 0 sits in the low bits, multi-byte fields are little-endian
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } usb_setup_fields_t;

  // Setup packet, filled byte by byte and read back as fields
  typedef union packed {
    logic [`USB_SETUP_BYTES-1:0][7:0] raw;
    usb_setup_fields_t                fields;
  } usb_setup_u;

endpackage

/* design/usb_token_decoder.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_token_decoder (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic [6:0]          usb_addr_i,
  input  logic                tok_recv_i,
  input  usb_pkg::usb_token_t tok_i,
  input  logic                seq_busy_i,
  output logic                req_valid_o,
  output xfer_pkg::xfer_req_t req_o,
  output logic [2:0]          ep_ce_o
);

  import usb_pkg::*;
  import xfer_pkg::*;

  logic       accept;
  logic       hit_ep0;
  logic       hit_ep1;
  logic       hit_ep2;
  logic       setup_ok;
  xfer_req_t  req_d;
  xfer_req_t  req_q;
  logic       req_valid_q;
  logic [2:0] ep_ce_q;

  // Our address, sequencer idle, and no request still in flight
  assign accept = tok_recv_i && (tok_i.addr == usb_addr_i) &&
                  !seq_busy_i && !req_valid_q;

  // Endpoint matches
  assign hit_ep0 = (tok_i.endp == 4'd0);
  assign hit_ep1 = (tok_i.endp == `USB_ENDPOINT1);
  assign hit_ep2 = (tok_i.endp == `USB_ENDPOINT2);

  // SETUP allowed on EP0 plus any control-capable bulk endpoint
  assign setup_ok = hit_ep0 ||
                    (`USB_EP1_CONTROL && hit_ep1) ||
                    (`USB_EP2_CONTROL && hit_ep2);

  // Classify the token
  always_comb begin
    req_d.ep    = {hit_ep2, hit_ep1, hit_ep0};
    req_d.is_in = (tok_i.tok_type == TOK_IN);
    case (tok_i.tok_type)
      TOK_OUT: begin
        req_d.xclass = (hit_ep1 || hit_ep2) ? CLS_BULK_OUT : CLS_UNSUPPORTED;
      end
      TOK_IN: begin
        req_d.xclass = (hit_ep1 || hit_ep2) ? CLS_BULK_IN : CLS_UNSUPPORTED;
      end
      TOK_SETUP: begin
        req_d.xclass = setup_ok ? CLS_CTRL_SETUP : CLS_UNSUPPORTED;
      end
      // Reserved code, e.g. SOF routed here by mistake
      default: begin
        req_d.xclass = CLS_UNSUPPORTED;
      end
    endcase
  end

  // Strobe and chip-enables
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
      ep_ce_q     <= 3'b000;
    end else begin
      req_valid_q <= accept;
      if (accept) begin
        // EP0 only selected by a control SETUP
        ep_ce_q[0] <= (tok_i.tok_type == TOK_SETUP) && hit_ep0;
        ep_ce_q[1] <= hit_ep1;
        ep_ce_q[2] <= hit_ep2;
      end
    end
  end

  // Request payload, qualified by req_valid
  always_ff @(posedge clock_i) begin
    if (accept) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;
  assign ep_ce_o     = ep_ce_q;

  // Sequencer must still be idle when the request lands
  assert property (@(posedge clock_i) disable iff (reset_i)
    req_valid_o |-> !seq_busy_i)
    else $error("token request issued while sequencer busy");

endmodule

/* design/usb_transaction.sv */
`timescale 1ns/1ps

module usb_transaction (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic [6:0]          usb_addr_i,
  // Token from the packet decoder
  input  logic                tok_recv_i,
  input  usb_pkg::usb_token_t tok_i,
  // OUT data byte stream
  input  logic                out_tvalid_i,
  input  logic                out_tlast_i,
  input  logic [7:0]          out_tdata_i,
  output logic                out_tready_o,
  // Endpoint side
  input  logic [2:0]          ep_ready_i,
  output logic [2:0]          ep_ce_o,
  // Host handshake received
  input  logic                hsk_recv_i,
  // Device handshake toward the encoder
  output logic                hsk_send_o,
  output usb_pkg::hsk_type_t  hsk_type_o,
  input  logic                hsk_sent_i,
  // Decoded setup packet
  output usb_pkg::usb_setup_u setup_o,
  output logic                setup_valid_o
);

  import usb_pkg::*;
  import xfer_pkg::*;

  logic      req_valid;
  xfer_req_t req;
  logic      seq_busy;
  logic      hsk_req;
  hsk_type_t hsk_req_type;
  logic      hsk_busy;

  // Input side
  usb_token_decoder u_token_decoder (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .usb_addr_i  (usb_addr_i),
    .tok_recv_i  (tok_recv_i),
    .tok_i       (tok_i),
    .seq_busy_i  (seq_busy),
    .req_valid_o (req_valid),
    .req_o       (req),
    .ep_ce_o     (ep_ce_o)
  );

  // Transaction control and setup capture
  usb_transaction_seq u_transaction_seq (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .out_tvalid_i   (out_tvalid_i),
    .out_tlast_i    (out_tlast_i),
    .out_tdata_i    (out_tdata_i),
    .ep_ready_i     (ep_ready_i),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_busy_i     (hsk_busy),
    .out_tready_o   (out_tready_o),
    .seq_busy_o     (seq_busy),
    .hsk_req_o      (hsk_req),
    .hsk_req_type_o (hsk_req_type),
    .setup_o        (setup_o),
    .setup_valid_o  (setup_valid_o)
  );

  // Output side
  usb_handshake_tx u_handshake_tx (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .hsk_req_i      (hsk_req),
    .hsk_req_type_i (hsk_req_type),
    .hsk_sent_i     (hsk_sent_i),
    .hsk_send_o     (hsk_send_o),
    .hsk_type_o     (hsk_type_o),
    .hsk_busy_o     (hsk_busy)
  );

endmodule

/* design/usb_transaction_seq.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_transaction_seq (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic                req_valid_i,
  input  xfer_pkg::xfer_req_t req_i,
  input  logic                out_tvalid_i,
  input  logic                out_tlast_i,
  input  logic [7:0]          out_tdata_i,
  input  logic [2:0]          ep_ready_i,
  input  logic                hsk_recv_i,
  input  logic                hsk_busy_i,
  output logic                out_tready_o,
  output logic                seq_busy_o,
  output logic                hsk_req_o,
  output usb_pkg::hsk_type_t  hsk_req_type_o,
  output usb_pkg::usb_setup_u setup_o,
  output logic                setup_valid_o
);

  import usb_pkg::*;
  import xfer_pkg::*;

  // Counter saturates one past the last setup byte
  localparam int CNT_W = $clog2(`USB_SETUP_BYTES + 1);
  localparam int IDX_W = $clog2(`USB_SETUP_BYTES);

  seq_state_t       state_q;
  logic [CNT_W-1:0] byte_cnt_q;
  logic             ep_ok_q;
  logic             hsk_req_q;
  hsk_type_t        hsk_type_q;
  logic             setup_ack_q;
  logic             setup_valid_q;
  usb_setup_u       setup_q;
  logic             beat;
  logic             last_beat;
  logic             store;

  // Byte transfers on valid and ready together
  assign beat      = out_tvalid_i && out_tready_o;
  assign last_beat = beat && out_tlast_i;

  // Only the first eight setup bytes are kept
  assign store = (state_q == ST_CTRL_SETUP) && beat &&
                 (byte_cnt_q < CNT_W'(`USB_SETUP_BYTES));

  // Accept bytes only while a data packet is expected
  assign out_tready_o = (state_q == ST_BULK_OUT) ||
                        (state_q == ST_CTRL_SETUP) ||
                        (state_q == ST_DRAIN);

  assign seq_busy_o = (state_q != ST_IDLE);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q       <= ST_IDLE;
      byte_cnt_q    <= '0;
      ep_ok_q       <= 1'b0;
      hsk_req_q     <= 1'b0;
      hsk_type_q    <= HSK_ACK;
      setup_ack_q   <= 1'b0;
      setup_valid_q <= 1'b0;
    end else begin
      // Strobes default low
      hsk_req_q     <= 1'b0;
      setup_ack_q   <= 1'b0;
      // Setup pulse trails the ACK request by one cycle
      setup_valid_q <= setup_ack_q;
      case (state_q)
        ST_IDLE: begin
          if (req_valid_i) begin
            byte_cnt_q <= '0;
            // Endpoint readiness sampled at request time
            ep_ok_q    <= |(ep_ready_i & req_i.ep);
            case (req_i.xclass)
              CLS_BULK_OUT: begin
                state_q <= ST_BULK_OUT;
              end
              CLS_BULK_IN: begin
                state_q <= ST_BULK_IN;
              end
              CLS_CTRL_SETUP: begin
                state_q <= ST_CTRL_SETUP;
              end
              default: begin
                // IN gets STALL now, OUT and SETUP drain their data first
                if (req_i.is_in) begin
                  state_q    <= ST_HSK_WAIT;
                  hsk_req_q  <= 1'b1;
                  hsk_type_q <= HSK_STALL;
                end else begin
                  state_q <= ST_DRAIN;
                end
              end
            endcase
          end
        end
        ST_BULK_OUT: begin
          if (last_beat) begin
            state_q    <= ST_HSK_WAIT;
            hsk_req_q  <= 1'b1;
            hsk_type_q <= ep_ok_q ? HSK_ACK : HSK_NAK;
          end
        end
        ST_BULK_IN: begin
          // Endpoint sends the data, host closes with its handshake
          if (hsk_recv_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_CTRL_SETUP: begin
          if (beat && (byte_cnt_q != CNT_W'(`USB_SETUP_BYTES))) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          if (last_beat) begin
            // Exact length gets ACK, anything else is dropped silently
            if (byte_cnt_q == CNT_W'(`USB_SETUP_BYTES - 1)) begin
              state_q     <= ST_HSK_WAIT;
              hsk_req_q   <= 1'b1;
              hsk_type_q  <= HSK_ACK;
              setup_ack_q <= 1'b1;
            end else begin
              state_q <= ST_IDLE;
            end
          end
        end
        ST_DRAIN: begin
          if (last_beat) begin
            state_q    <= ST_HSK_WAIT;
            hsk_req_q  <= 1'b1;
            hsk_type_q <= HSK_STALL;
          end
        end
        ST_HSK_WAIT: begin
          // Issuer raises busy one cycle after the request
          if (!hsk_req_q && !hsk_busy_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Setup bytes land at their own index
  always_ff @(posedge clock_i) begin
    if (store) begin
      setup_q.raw[byte_cnt_q[IDX_W-1:0]] <= out_tdata_i;
    end
  end

  assign hsk_req_o      = hsk_req_q;
  assign hsk_req_type_o = hsk_type_q;
  assign setup_o        = setup_q;
  assign setup_valid_o  = setup_valid_q;

  // Issuer must be free for every new request
  assert property (@(posedge clock_i) disable iff (reset_i)
    hsk_req_o |-> !hsk_busy_i)
    else $error("handshake requested while issuer busy");

  // No byte accepted while a device handshake is still pending
  assert property (@(posedge clock_i) disable iff (reset_i)
    hsk_busy_i |-> !out_tready_o)
    else $error("out_tready high while handshake pending");

endmodule

/* design/xfer_pkg.sv */
package xfer_pkg;

  // What the sequencer should do with an accepted token
  typedef enum logic [1:0] {
    CLS_BULK_OUT,
    CLS_BULK_IN,
    CLS_CTRL_SETUP,
    CLS_UNSUPPORTED
  } xfer_class_t;

  // Request from token decoder to sequencer
  typedef struct packed {
    xfer_class_t xclass;
    // Token direction, picks STALL timing for unsupported tokens
    logic        is_in;
    // One-hot endpoint, bit 0 is EP0
    logic [2:0]  ep;
  } xfer_req_t;

  // Transaction sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_BULK_OUT,
    ST_BULK_IN,
    ST_CTRL_SETUP,
    ST_DRAIN,
    ST_HSK_WAIT
  } seq_state_t;

endpackage

/* tb/tb_usb_transaction_table.svh */
`ifndef TB_USB_TRANSACTION_TABLE_SVH
`define TB_USB_TRANSACTION_TABLE_SVH

// One transaction per row, expected results alongside
typedef struct packed {
  tok_type_t   tok_type;
  logic [6:0]  addr;
  logic [3:0]  endp;
  // OUT or SETUP data payload length
  logic [3:0]  n_bytes;
  logic [2:0]  ep_ready;
  logic [2:0]  exp_ce;
  logic        exp_hsk;
  hsk_type_t   exp_hsk_type;
  logic        exp_setup;
  logic [15:0] exp_w_length;
  logic [7:0]  exp_b_request;
  // Extra token thrown in while the handshake is pending
  logic        busy_tok;
} row_t;

localparam int         NUM_ROWS     = 13;
localparam logic [6:0] DEV_ADDR     = 7'h2a;
localparam logic [6:0] FOREIGN_ADDR = 7'h15;

row_t  rows      [NUM_ROWS];
string row_names [NUM_ROWS];

// Field order follows row_t
task automatic load_rows();
  row_names[0]  = "out_ep1_ack";
  rows[0]       = '{TOK_OUT, DEV_ADDR, `USB_ENDPOINT1, 4'd4, 3'b010, 3'b010,
                    1'b1, HSK_ACK, 1'b0, 16'h0000, 8'h00, 1'b0};
  row_names[1]  = "out_ep1_nak";
  rows[1]       = '{TOK_OUT, DEV_ADDR, `USB_ENDPOINT1, 4'd3, 3'b101, 3'b010,
                    1'b1, HSK_NAK, 1'b0, 16'h0000, 8'h00, 1'b0};
  row_names[2]  = "out_ep2_ack_busy_token";
  rows[2]       = '{TOK_OUT, DEV_ADDR, `USB_ENDPOINT2, 4'd6, 3'b100, 3'b100,
                    1'b1, HSK_ACK, 1'b0, 16'h0000, 8'h00, 1'b1};
  // Chip-enables keep the previous row's value
  row_names[3]  = "other_address";
  rows[3]       = '{TOK_OUT, FOREIGN_ADDR, `USB_ENDPOINT1, 4'd0, 3'b111, 3'b100,
                    1'b0, HSK_ACK, 1'b0, 16'h0000, 8'h00, 1'b0};
  row_names[4]  = "out_ep2_nak";
  rows[4]       = '{TOK_OUT, DEV_ADDR, `USB_ENDPOINT2, 4'd2, 3'b011, 3'b100,
                    1'b1, HSK_NAK, 1'b0, 16'h0000, 8'h00, 1'b0};
  row_names[5]  = "setup_ep0_ack";
  rows[5]       = '{TOK_SETUP, DEV_ADDR, 4'd0, 4'd8, 3'b000, 3'b001,
                    1'b1, HSK_ACK, 1'b1, 16'h0040, 8'h06, 1'b0};
  // Wrong length, dropped without a handshake
  row_names[6]  = "setup_ep0_short";
  rows[6]       = '{TOK_SETUP, DEV_ADDR, 4'd0, 4'd5, 3'b000, 3'b001,
                    1'b0, HSK_ACK, 1'b0, 16'h0000, 8'h05, 1'b0};
  row_names[7]  = "setup_ep1_stall";
  rows[7]       = '{TOK_SETUP, DEV_ADDR, `USB_ENDPOINT1, 4'd8, 3'b111, 3'b010,
                    1'b1, HSK_STALL, 1'b0, 16'h0000, 8'h08, 1'b0};
  row_names[8]  = "out_ep3_stall";
  rows[8]       = '{TOK_OUT, DEV_ADDR, 4'd3, 4'd4, 3'b111, 3'b000,
                    1'b1, HSK_STALL, 1'b0, 16'h0000, 8'h00, 1'b0};
  row_names[9]  = "in_ep0_stall";
  rows[9]       = '{TOK_IN, DEV_ADDR, 4'd0, 4'd0, 3'b111, 3'b000,
                    1'b1, HSK_STALL, 1'b0, 16'h0000, 8'h00, 1'b0};
  // Host handshake closes it, no device handshake
  row_names[10] = "in_ep2_bulk";
  rows[10]      = '{TOK_IN, DEV_ADDR, `USB_ENDPOINT2, 4'd0, 3'b100, 3'b100,
                    1'b0, HSK_ACK, 1'b0, 16'h0000, 8'h00, 1'b0};
  row_names[11] = "out_ep1_after_in";
  rows[11]      = '{TOK_OUT, DEV_ADDR, `USB_ENDPOINT1, 4'd4, 3'b010, 3'b010,
                    1'b1, HSK_ACK, 1'b0, 16'h0000, 8'h00, 1'b1};
  row_names[12] = "setup_ep2_ack";
  rows[12]      = '{TOK_SETUP, DEV_ADDR, `USB_ENDPOINT2, 4'd8, 3'b000, 3'b100,
                    1'b1, HSK_ACK, 1'b1, 16'h0102, 8'h0b, 1'b0};
endtask

`endif

/* tb/tb_usb_transaction.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module tb_usb_transaction;

  import usb_pkg::*;

  `include "tb_usb_transaction_table.svh"

  // Bound on every wait, in clock cycles
  localparam int TIMEOUT = 200;
  // Idle cycles after each row
  localparam int GAP     = 4;

  logic       clock = 1'b0;
  logic       reset;
  logic [6:0] usb_addr;
  logic       tok_recv;
  usb_token_t tok;
  logic       out_tvalid;
  logic       out_tlast;
  logic [7:0] out_tdata;
  logic       out_tready;
  logic [2:0] ep_ready;
  logic [2:0] ep_ce;
  logic       hsk_recv;
  logic       hsk_send;
  hsk_type_t  hsk_type;
  logic       hsk_sent;
  usb_setup_u setup;
  logic       setup_valid;

  integer      seed          = 2;
  string       cur_name      = "reset";
  int          hsk_count     = 0;
  int          setup_count   = 0;
  logic        send_prev     = 1'b0;
  hsk_type_t   type_prev;
  logic [7:0]  got_b_request = 8'h00;
  logic [15:0] got_w_length  = 16'h0000;

  always #4 clock = ~clock;

  usb_transaction u_usb_transaction (
    .clock_i       (clock),
    .reset_i       (reset),
    .usb_addr_i    (usb_addr),
    .tok_recv_i    (tok_recv),
    .tok_i         (tok),
    .out_tvalid_i  (out_tvalid),
    .out_tlast_i   (out_tlast),
    .out_tdata_i   (out_tdata),
    .out_tready_o  (out_tready),
    .ep_ready_i    (ep_ready),
    .ep_ce_o       (ep_ce),
    .hsk_recv_i    (hsk_recv),
    .hsk_send_o    (hsk_send),
    .hsk_type_o    (hsk_type),
    .hsk_sent_i    (hsk_sent),
    .setup_o       (setup),
    .setup_valid_o (setup_valid)
  );

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL %s %s expected %0h actual %0h", cur_name, what, expected, actual);
    stop_on_failure();
  endtask

  task automatic report_error(input string msg);
    $display("Error in test %s, %s", cur_name, msg);
    stop_on_failure();
  endtask

  // Handshake and setup pulses, seen at the clock edge
  always @(posedge clock) begin
    if (!reset) begin
      if (hsk_send && !send_prev) begin
        hsk_count = hsk_count + 1;
      end
      // Type may not move while the send line is up
      if (hsk_send && send_prev) begin
        assert (hsk_type == type_prev) else report_mismatch("held hsk_type", type_prev, hsk_type);
      end
      if (setup_valid) begin
        setup_count   = setup_count + 1;
        got_b_request = setup.fields.b_request;
        got_w_length  = setup.fields.w_length;
      end
    end
    send_prev = hsk_send;
    type_prev = hsk_type;
  end

  // One-cycle token pulse
  task automatic send_token(input tok_type_t tt, input logic [6:0] addr, input logic [3:0] endp);
    tok.tok_type = tt;
    tok.addr     = addr;
    tok.endp     = endp;
    tok_recv     = 1'b1;
    @(negedge clock);
    tok_recv     = 1'b0;
  endtask

  // Byte moves on the rising edge after tready is seen high
  task automatic send_byte(input logic [7:0] data, input logic last);
    int waited;
    out_tvalid = 1'b1;
    out_tdata  = data;
    out_tlast  = last;
    waited     = 0;
    while (!out_tready) begin
      @(negedge clock);
      waited++;
      if (waited > TIMEOUT) begin
        report_error("timed out waiting for out_tready");
      end
    end
    @(negedge clock);
    out_tvalid = 1'b0;
    out_tlast  = 1'b0;
  endtask

  // Counting pattern, setup rows carry bRequest and wLength at their offsets
  function automatic logic [7:0] byte_value(input int idx, input int k);
    row_t r;
    r = rows[idx];
    byte_value = 8'(k + idx);
    if (r.tok_type == TOK_SETUP) begin
      if (k == 1) begin
        byte_value = r.exp_b_request;
      end else if (k == 6) begin
        byte_value = r.exp_w_length[7:0];
      end else if (k == 7) begin
        byte_value = r.exp_w_length[15:8];
      end
    end
  endfunction

  // Encoder side, random delay before hsk_sent
  task automatic answer_handshake(input row_t r);
    int waited;
    int delay;
    int c;
    waited = 0;
    while (!hsk_send) begin
      @(negedge clock);
      waited++;
      if (waited > TIMEOUT) begin
        report_error("timed out waiting for hsk_send");
      end
    end
    assert (hsk_type == r.exp_hsk_type) else report_mismatch("hsk_type", r.exp_hsk_type, hsk_type);
    // Sequencer busy, this token must be ignored
    if (r.busy_tok) begin
      send_token(TOK_SETUP, DEV_ADDR, 4'd0);
    end
    delay = {$random(seed)} % 6;
    for (c = 0; c < delay; c++) begin
      assert (hsk_send) else report_error("hsk_send dropped before hsk_sent");
      @(negedge clock);
    end
    assert (hsk_send) else report_error("hsk_send dropped before hsk_sent");
    hsk_sent = 1'b1;
    @(negedge clock);
    hsk_sent = 1'b0;
    assert (!hsk_send) else report_error("hsk_send still high after hsk_sent");
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   k;
    r           = rows[idx];
    cur_name    = row_names[idx];
    hsk_count   = 0;
    setup_count = 0;
    ep_ready    = r.ep_ready;
    send_token(r.tok_type, r.addr, r.endp);
    for (k = 0; k < r.n_bytes; k++) begin
      send_byte(byte_value(idx, k), k == r.n_bytes - 1);
    end
    // Bulk IN, host handshake a few cycles after the token
    if (r.tok_type == TOK_IN && !r.exp_hsk) begin
      repeat (3) @(negedge clock);
      hsk_recv = 1'b1;
      @(negedge clock);
      hsk_recv = 1'b0;
    end
    if (r.exp_hsk) begin
      answer_handshake(r);
    end
    repeat (GAP) begin
      @(negedge clock);
      assert (!out_tready) else report_error("out_tready high after the transaction");
    end
    assert (ep_ce == r.exp_ce) else report_mismatch("ep_ce", r.exp_ce, ep_ce);
    assert (hsk_count == int'(r.exp_hsk)) else
      report_mismatch("handshake count", r.exp_hsk, hsk_count);
    assert (setup_count == int'(r.exp_setup)) else
      report_mismatch("setup_valid count", r.exp_setup, setup_count);
    if (r.exp_setup) begin
      assert (got_b_request == r.exp_b_request) else
        report_mismatch("bRequest", r.exp_b_request, got_b_request);
      assert (got_w_length == r.exp_w_length) else
        report_mismatch("wLength", r.exp_w_length, got_w_length);
    end
  endtask

  initial begin
    int idx;
    reset      = 1'b1;
    usb_addr   = DEV_ADDR;
    tok_recv   = 1'b0;
    tok        = '0;
    out_tvalid = 1'b0;
    out_tlast  = 1'b0;
    out_tdata  = 8'h00;
    ep_ready   = 3'b000;
    hsk_recv   = 1'b0;
    hsk_sent   = 1'b0;
    load_rows();
    repeat (8) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    // Everything quiet out of reset
    assert (ep_ce == 3'b000) else report_mismatch("ep_ce", 3'b000, ep_ce);
    assert (!out_tready && !hsk_send && !setup_valid) else
      report_error("outputs not low after reset");
    for (idx = 0; idx < NUM_ROWS; idx++) begin
      run_row(idx);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* usb_transaction.f */
+incdir+design
+incdir+tb
design/usb_pkg.sv
design/xfer_pkg.sv
design/usb_token_decoder.sv
design/usb_transaction_seq.sv
design/usb_handshake_tx.sv
design/usb_transaction.sv
tb/tb_usb_transaction.sv
